// ==== common/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // preamble is seven 0x55 bytes, 01 on every dibit
    localparam int PREAMBLE_DIBITS = 28;

    // start frame delimiter 0xD5, one byte
    localparam int SFD_DIBITS = 4;

    // one 48-bit mac address
    localparam int ADDR_DIBITS = 24;

    // ethertype or length word
    localparam int TYPE_DIBITS = 8;

    // frame check sequence, 32 bits
    localparam int FCS_DIBITS = 16;

    // crc-32 seed and final complement
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_RESIDUE_XOR = 32'hFFFF_FFFF;

    // rmii transmit pins toward the phy
    typedef struct packed {
        logic       txen;
        // txd[0] is the earlier bit on the wire
        logic [1:0] txd;
    } rmii_tx_t;

    // byte stream from the payload producer
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // dibit stream from the buffer to the packer
    typedef struct packed {
        logic       valid;
        logic [1:0] data;
    } dibit_beat_t;

    // frame sequencer states, in transmit order
    typedef enum logic [2:0] {
        ST_GAP      = 3'd0,
        ST_PREAMBLE = 3'd1,
        ST_SFD      = 3'd2,
        ST_DEST     = 3'd3,
        ST_SRC      = 3'd4,
        ST_ETHTYPE  = 3'd5,
        ST_PAYLOAD  = 3'd6,
        ST_FCS      = 3'd7
    } packer_state_t;

endpackage

// ==== eth_packer/crc32_dibit.sv ====
`timescale 1ns/1ns

module crc32_dibit (
    input  logic        clk,
    input  logic        rst,
    input  logic        crc_clear,
    input  logic        crc_en,
    input  logic [1:0]  crc_din,
    output logic [31:0] crc_out
);

    // 0x04C11DB7 bit reversed
    localparam logic [31:0] POLY_REFL = 32'hEDB8_8320;

    logic [31:0] crc_q;
    logic [31:0] step_one;
    logic [31:0] step_two;

    // one serial lfsr step, shifting toward bit 0
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
        logic fb;
        fb = c[0] ^ b;
        return (c >> 1) ^ (fb ? POLY_REFL : 32'h0);
    endfunction

    // low bit of the dibit is first on the wire
    always_comb begin
        step_one = crc_step(crc_q, crc_din[0]);
        step_two = crc_step(step_one, crc_din[1]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= eth_tx_pkg::CRC_INIT;
        end else if (crc_clear) begin
            // clear wins over enable
            crc_q <= eth_tx_pkg::CRC_INIT;
        end else if (crc_en) begin
            crc_q <= step_two;
        end
    end

    // fcs is the complemented register
    assign crc_out = crc_q ^ eth_tx_pkg::CRC_RESIDUE_XOR;

endmodule

// ==== eth_packer/eth_packer.sv ====
`timescale 1ns/1ns

module eth_packer #(
    parameter int          PAYLOAD_BYTES = 46,
    parameter int          IFG_DIBITS    = 48,
    parameter logic [47:0] DEST_ADDR     = 48'hFFFF_FFFF_FFFF,
    parameter logic [47:0] SRC_ADDR      = 48'h0200_0000_0001,
    parameter logic [15:0] ETHER_TYPE    = 16'h88B5
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cancel,
    input  logic                    frame_avail,
    input  eth_tx_pkg::dibit_beat_t dibit_in,
    output logic                    take,
    output logic                    frame_start,
    output logic                    flush,
    output eth_tx_pkg::rmii_tx_t    phy
);

    // payload is the longest field, preamble the next
    localparam int FIELD_MAX = (4 * PAYLOAD_BYTES > 32) ? 4 * PAYLOAD_BYTES : 32;
    localparam int CNT_W = $clog2(FIELD_MAX + 1);
    localparam int GAP_W = $clog2(IFG_DIBITS + 1);
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    localparam logic [1:0] PRE_DIBIT = 2'b01;

    eth_tx_pkg::packer_state_t state;

    logic [CNT_W-1:0] dcnt;
    logic [CNT_W-1:0] field_last;
    logic [GAP_W-1:0] gap_cnt;
    logic             gap_done;
    logic             field_done;
    logic [1:0]       tx_dibit;
    logic             crc_clear;
    logic             crc_en;
    logic [31:0]      crc_out;

    // dibit idx of a field in wire order
    // bytes msb first, bit pairs lsb first within a byte
    function automatic logic [1:0] wire_dibit(
        input logic [47:0]      v,
        input int               nbytes,
        input logic [CNT_W-1:0] idx
    );
        int lo;
        lo = 8 * (nbytes - 1 - int'(idx[CNT_W-1:2])) + 2 * int'(idx[1:0]);
        return v[lo +: 2];
    endfunction

    // index of the last dibit in the current field
    always_comb begin
        case (state)
            eth_tx_pkg::ST_PREAMBLE: field_last = CNT_W'(eth_tx_pkg::PREAMBLE_DIBITS - 1);
            eth_tx_pkg::ST_SFD:      field_last = CNT_W'(eth_tx_pkg::SFD_DIBITS - 1);
            eth_tx_pkg::ST_DEST:     field_last = CNT_W'(eth_tx_pkg::ADDR_DIBITS - 1);
            eth_tx_pkg::ST_SRC:      field_last = CNT_W'(eth_tx_pkg::ADDR_DIBITS - 1);
            eth_tx_pkg::ST_ETHTYPE:  field_last = CNT_W'(eth_tx_pkg::TYPE_DIBITS - 1);
            eth_tx_pkg::ST_PAYLOAD:  field_last = CNT_W'(4 * PAYLOAD_BYTES - 1);
            eth_tx_pkg::ST_FCS:      field_last = CNT_W'(eth_tx_pkg::FCS_DIBITS - 1);
            default:                 field_last = '0;
        endcase
    end

    assign field_done = (dcnt == field_last);
    assign gap_done = (gap_cnt == GAP_W'(IFG_DIBITS - 1));

    // dibit for the next clock, also fed to the crc
    always_comb begin
        case (state)
            eth_tx_pkg::ST_PREAMBLE: tx_dibit = PRE_DIBIT;
            eth_tx_pkg::ST_SFD:      tx_dibit = SFD_BYTE[{dcnt[1:0], 1'b0} +: 2];
            eth_tx_pkg::ST_DEST:     tx_dibit = wire_dibit(DEST_ADDR, 6, dcnt);
            eth_tx_pkg::ST_SRC:      tx_dibit = wire_dibit(SRC_ADDR, 6, dcnt);
            eth_tx_pkg::ST_ETHTYPE:  tx_dibit = wire_dibit({32'h0, ETHER_TYPE}, 2, dcnt);
            eth_tx_pkg::ST_PAYLOAD:  tx_dibit = dibit_in.valid ? dibit_in.data : 2'b00;
            // complemented crc, bit 0 first
            eth_tx_pkg::ST_FCS:      tx_dibit = crc_out[{dcnt[3:0], 1'b0} +: 2];
            default:                 tx_dibit = 2'b00;
        endcase
    end

    // buffer handshake
    assign take = (state == eth_tx_pkg::ST_PAYLOAD) && dibit_in.valid;
    assign frame_start = (state == eth_tx_pkg::ST_GAP) && gap_done && frame_avail && !cancel;
    // buffer ignores flush once the payload is fully popped
    assign flush = cancel && (state != eth_tx_pkg::ST_GAP);

    // checksum covers header and payload only
    assign crc_clear = (state == eth_tx_pkg::ST_GAP) || cancel;
    assign crc_en = (state == eth_tx_pkg::ST_DEST) || (state == eth_tx_pkg::ST_SRC) ||
                    (state == eth_tx_pkg::ST_ETHTYPE) || (state == eth_tx_pkg::ST_PAYLOAD);

    crc32_dibit u_crc (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_din   (tx_dibit),
        .crc_out   (crc_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= eth_tx_pkg::ST_GAP;
            dcnt <= '0;
            gap_cnt <= '0;
            phy <= '0;
        end else if (cancel) begin
            // abort, txen low next clock and a fresh gap
            state <= eth_tx_pkg::ST_GAP;
            dcnt <= '0;
            gap_cnt <= '0;
            phy <= '0;
        end else begin
            // phy trails the state by one clock
            phy.txen <= (state != eth_tx_pkg::ST_GAP);
            phy.txd <= tx_dibit;
            if (state == eth_tx_pkg::ST_GAP) begin
                dcnt <= '0;
                if (!gap_done) begin
                    gap_cnt <= gap_cnt + 1'b1;
                end else if (frame_avail) begin
                    state <= eth_tx_pkg::ST_PREAMBLE;
                end
            end else if (!field_done) begin
                dcnt <= dcnt + 1'b1;
            end else begin
                dcnt <= '0;
                case (state)
                    eth_tx_pkg::ST_PREAMBLE: state <= eth_tx_pkg::ST_SFD;
                    eth_tx_pkg::ST_SFD:      state <= eth_tx_pkg::ST_DEST;
                    eth_tx_pkg::ST_DEST:     state <= eth_tx_pkg::ST_SRC;
                    eth_tx_pkg::ST_SRC:      state <= eth_tx_pkg::ST_ETHTYPE;
                    eth_tx_pkg::ST_ETHTYPE:  state <= eth_tx_pkg::ST_PAYLOAD;
                    eth_tx_pkg::ST_PAYLOAD:  state <= eth_tx_pkg::ST_FCS;
                    default: begin
                        // end of fcs, start the inter-frame gap
                        state <= eth_tx_pkg::ST_GAP;
                        gap_cnt <= '0;
                    end
                endcase
            end
        end
    end

endmodule

// ==== verilog/payload_buffer.sv ====
`timescale 1ns/1ns

module payload_buffer #(
    parameter int PAYLOAD_BYTES = 46,
    parameter int FIFO_BYTES    = 128
) (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_tx_pkg::byte_beat_t  in_beat,
    output logic                    in_ready,
    output logic                    frame_avail,
    input  logic                    frame_start,
    input  logic                    take,
    input  logic                    flush,
    output eth_tx_pkg::dibit_beat_t dibit_out
);

    localparam int PTR_W = $clog2(FIFO_BYTES);
    localparam int CNT_W = $clog2(FIFO_BYTES + 1);
    localparam int FRM_W = $clog2(PAYLOAD_BYTES + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_BYTES - 1);
    localparam logic [CNT_W-1:0] DEPTH = CNT_W'(FIFO_BYTES);
    localparam logic [CNT_W-1:0] FRAME_LEN = CNT_W'(PAYLOAD_BYTES);
    localparam logic [FRM_W-1:0] LAST_BYTE = FRM_W'(PAYLOAD_BYTES - 1);

    logic [7:0]       mem [FIFO_BYTES];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // which bit pair of the head byte goes out next
    logic [1:0]       phase;
    logic             locked;
    logic [FRM_W-1:0] popped;

    logic             push;
    logic             step;
    logic             pop;
    logic             drop_frame;
    logic [CNT_W-1:0] remaining;
    logic [CNT_W-1:0] drop_cnt;
    logic [CNT_W:0]   flush_sum;
    logic [PTR_W-1:0] flush_ptr;

    assign in_ready = (count != DEPTH);
    assign push = in_beat.valid && in_ready;

    // a full payload waiting and no frame in readout
    assign frame_avail = !locked && (count >= FRAME_LEN);

    assign dibit_out.valid = (count != '0);
    assign dibit_out.data = mem[rd_ptr][{phase, 1'b0} +: 2];

    // byte leaves after its fourth dibit
    assign step = take && dibit_out.valid;
    assign pop = step && (phase == 2'd3);

    // cancel only matters while a frame is locked
    assign drop_frame = flush && locked;
    assign remaining = FRAME_LEN - CNT_W'(popped);

    // skip the rest of the locked frame, modulo depth
    always_comb begin
        flush_sum = (CNT_W + 1)'(rd_ptr) + (CNT_W + 1)'(remaining);
        if (flush_sum >= (CNT_W + 1)'(FIFO_BYTES)) begin
            flush_sum = flush_sum - (CNT_W + 1)'(FIFO_BYTES);
        end
        flush_ptr = PTR_W'(flush_sum);
    end

    always_comb begin
        if (drop_frame) begin
            drop_cnt = remaining;
        end else if (pop) begin
            drop_cnt = CNT_W'(1);
        end else begin
            drop_cnt = '0;
        end
    end

    // storage only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            phase <= '0;
            locked <= 1'b0;
            popped <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (drop_frame) begin
                rd_ptr <= flush_ptr;
                phase <= '0;
                locked <= 1'b0;
            end else begin
                if (step) begin
                    phase <= phase + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
                end
                if (frame_start) begin
                    locked <= 1'b1;
                    popped <= '0;
                end else if (pop && locked) begin
                    // unlock on the last payload byte
                    if (popped == LAST_BYTE) begin
                        locked <= 1'b0;
                    end
                    popped <= popped + 1'b1;
                end
            end
            count <= count + CNT_W'(push) - drop_cnt;
        end
    end

endmodule

// ==== verilog/eth_tx_top.sv ====
`timescale 1ns/1ns

module eth_tx_top #(
    parameter int          PAYLOAD_BYTES = 46,
    // must hold at least one payload
    parameter int          FIFO_BYTES    = 128,
    // 96 bit times at two bits per clock
    parameter int          IFG_DIBITS    = 48,
    parameter logic [47:0] DEST_ADDR     = 48'hFFFF_FFFF_FFFF,
    parameter logic [47:0] SRC_ADDR      = 48'h0200_0000_0001,
    parameter logic [15:0] ETHER_TYPE    = 16'h88B5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cancel,
    input  eth_tx_pkg::byte_beat_t payload_in,
    output logic                   payload_ready,
    output eth_tx_pkg::rmii_tx_t   phy
);

    logic                    frame_avail;
    logic                    frame_start;
    logic                    take;
    logic                    flush;
    eth_tx_pkg::dibit_beat_t dibit;

    // buffers whole payloads, serves dibits lsb first
    payload_buffer #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES),
        .FIFO_BYTES    (FIFO_BYTES)
    ) u_buffer (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (payload_in),
        .in_ready    (payload_ready),
        .frame_avail (frame_avail),
        .frame_start (frame_start),
        .take        (take),
        .flush       (flush),
        .dibit_out   (dibit)
    );

    // frame sequencer and fcs
    eth_packer #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES),
        .IFG_DIBITS    (IFG_DIBITS),
        .DEST_ADDR     (DEST_ADDR),
        .SRC_ADDR      (SRC_ADDR),
        .ETHER_TYPE    (ETHER_TYPE)
    ) u_packer (
        .clk         (clk),
        .rst         (rst),
        .cancel      (cancel),
        .frame_avail (frame_avail),
        .dibit_in    (dibit),
        .take        (take),
        .frame_start (frame_start),
        .flush       (flush),
        .phy         (phy)
    );

endmodule

// ==== sim/eth_tx_tb.sv ====
`timescale 1ns/1ns

module eth_tx_tb;

    localparam int PAYLOAD_BYTES = 46;
    localparam int FIFO_BYTES = 128;
    localparam int IFG_DIBITS = 48;
    localparam logic [47:0] DEST_ADDR = 48'h0A1B_2C3D_4E5F;
    localparam logic [47:0] SRC_ADDR = 48'h0200_0000_0001;
    localparam logic [15:0] ETHER_TYPE = 16'h88B5;

    // dest, src and ethertype bytes
    localparam int HDR_BYTES = 14;
    // sfd byte leads the bytes after the preamble
    localparam int WIRE_BYTES = 1 + HDR_BYTES + PAYLOAD_BYTES;
    localparam int FRAME_CLOCKS = eth_tx_pkg::PREAMBLE_DIBITS + eth_tx_pkg::SFD_DIBITS +
                                  2 * eth_tx_pkg::ADDR_DIBITS + eth_tx_pkg::TYPE_DIBITS +
                                  4 * PAYLOAD_BYTES + eth_tx_pkg::FCS_DIBITS;
    localparam int N_FRAMES = 7;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CHECK_CLOCKS = 20;
    localparam int CLK_NS = 8;
    localparam longint WATCHDOG_NS = 2 * CLK_NS *
        (N_FRAMES * (FRAME_CLOCKS + IFG_DIBITS + 4 * PAYLOAD_BYTES) + RESET_CYCLES);

    localparam int MODE_INCR = 0;
    localparam int MODE_FIXED = 1;
    localparam int MODE_RAND = 2;
    localparam int NO_CANCEL = -1;

    localparam eth_tx_pkg::rmii_tx_t PHY_IDLE = '{txen: 1'b0, txd: 2'b00};
    localparam eth_tx_pkg::rmii_tx_t PHY_PRE = '{txen: 1'b1, txd: 2'b01};

    // frame table with one column per array
    // stall mask bit j%8 idles the producer one clock before byte j
    // cancel offset counts txen high clocks before the abort takes effect
    string      test_name [N_FRAMES] = '{"incrementing", "fixed_pattern", "random_stall",
                                         "cancel_payload", "after_cancel", "cancel_preamble",
                                         "random_tail"};
    int         gen_mode [N_FRAMES] = '{MODE_INCR, MODE_FIXED, MODE_RAND, MODE_INCR,
                                        MODE_RAND, MODE_FIXED, MODE_RAND};
    logic [7:0] stall_mask [N_FRAMES] = '{8'h00, 8'h00, 8'h25, 8'h00, 8'h81, 8'h00, 8'h10};
    int         cancel_at [N_FRAMES] = '{NO_CANCEL, NO_CANCEL, NO_CANCEL, 150,
                                         NO_CANCEL, 10, NO_CANCEL};

    logic                   clk;
    logic                   rst;
    logic                   cancel;
    eth_tx_pkg::byte_beat_t payload_in;
    logic                   payload_ready;
    eth_tx_pkg::rmii_tx_t   phy;

    logic [7:0]           payload [N_FRAMES][PAYLOAD_BYTES];
    logic [7:0]           exp_bytes [WIRE_BYTES];
    eth_tx_pkg::rmii_tx_t cur_frame [$];
    eth_tx_pkg::rmii_tx_t last_frame [$];
    int                   frames_seen;
    int                   idle_clocks;
    int                   gap_errs;
    int                   err_cnt;
    int                   check_cnt;
    bit                   saw_full;

    eth_tx_top #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES),
        .FIFO_BYTES    (FIFO_BYTES),
        .IFG_DIBITS    (IFG_DIBITS),
        .DEST_ADDR     (DEST_ADDR),
        .SRC_ADDR      (SRC_ADDR),
        .ETHER_TYPE    (ETHER_TYPE)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .cancel        (cancel),
        .payload_in    (payload_in),
        .payload_ready (payload_ready),
        .phy           (phy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // monitor samples phy at the falling edge where it is stable
    always @(negedge clk) begin
        if (!rst) begin
            if (phy.txen) begin
                if (cur_frame.size() == 0 && frames_seen > 0 && idle_clocks < IFG_DIBITS) begin
                    $display("gap before frame %0d was only %0d clocks", frames_seen,
                             idle_clocks);
                    gap_errs++;
                end
                cur_frame.push_back(phy);
                idle_clocks = 0;
            end else begin
                // txen fell so the frame is complete
                if (cur_frame.size() != 0) begin
                    last_frame = cur_frame;
                    cur_frame.delete();
                    frames_seen++;
                end
                idle_clocks++;
            end
        end
    end

    task automatic check_phy(input string name, input eth_tx_pkg::rmii_tx_t exp,
                             input eth_tx_pkg::rmii_tx_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Error %s: expected txen=%b txd=%b, actual txen=%b txd=%b",
                     name, exp.txen, exp.txd, act.txen, act.txd);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Error %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_fcs(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic make_payloads();
        for (int i = 0; i < N_FRAMES; i++) begin
            for (int j = 0; j < PAYLOAD_BYTES; j++) begin
                case (gen_mode[i])
                    MODE_INCR:  payload[i][j] = 8'(i * 16 + j);
                    MODE_FIXED: payload[i][j] = (j % 2 == 1) ? 8'h5A : 8'hA5;
                    default:    payload[i][j] = 8'($urandom);
                endcase
            end
        end
    endtask

    // sfd, addresses msb byte first, ethertype, then the payload
    task automatic build_expected(input int f);
        exp_bytes[0] = 8'hD5;
        for (int k = 0; k < 6; k++) begin
            exp_bytes[1 + k] = DEST_ADDR[47 - 8 * k -: 8];
            exp_bytes[7 + k] = SRC_ADDR[47 - 8 * k -: 8];
        end
        exp_bytes[13] = ETHER_TYPE[15:8];
        exp_bytes[14] = ETHER_TYPE[7:0];
        for (int j = 0; j < PAYLOAD_BYTES; j++) begin
            exp_bytes[1 + HDR_BYTES + j] = payload[f][j];
        end
    endtask

    // bitwise crc-32 from dest through payload, lsb of each byte first
    function automatic logic [31:0] ref_fcs();
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int k = 1; k < WIRE_BYTES; k++) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ exp_bytes[k][b]) begin
                    c = (c >> 1) ^ 32'hEDB8_8320;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return ~c;
    endfunction

    task automatic score_frame(input int f);
        int          n;
        int          base;
        logic [7:0]  b;
        logic [31:0] fcs;
        n = last_frame.size();
        build_expected(f);
        check_count($sformatf("%s length", test_name[f]),
                    (cancel_at[f] == NO_CANCEL) ? FRAME_CLOCKS : cancel_at[f], n);
        for (int i = 0; i < eth_tx_pkg::PREAMBLE_DIBITS && i < n; i++) begin
            check_phy($sformatf("%s preamble %0d", test_name[f], i), PHY_PRE, last_frame[i]);
        end
        // only bytes that went out in full
        for (int k = 0; k < WIRE_BYTES; k++) begin
            base = eth_tx_pkg::PREAMBLE_DIBITS + 4 * k;
            if (base + 3 < n) begin
                for (int d = 0; d < 4; d++) begin
                    b[2 * d +: 2] = last_frame[base + d].txd;
                end
                check_byte($sformatf("%s byte %0d", test_name[f], k), exp_bytes[k], b);
            end
        end
        if (n == FRAME_CLOCKS) begin
            base = eth_tx_pkg::PREAMBLE_DIBITS + 4 * WIRE_BYTES;
            for (int d = 0; d < eth_tx_pkg::FCS_DIBITS; d++) begin
                fcs[2 * d +: 2] = last_frame[base + d].txd;
            end
            check_fcs($sformatf("%s fcs", test_name[f]), ref_fcs(), fcs);
        end
    endtask

    // all payloads back to back, held off while the fifo is full
    task automatic produce();
        for (int f = 0; f < N_FRAMES; f++) begin
            for (int j = 0; j < PAYLOAD_BYTES; j++) begin
                if (stall_mask[f][j % 8]) begin
                    payload_in.valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
                payload_in.valid = 1'b1;
                payload_in.data = payload[f][j];
                // ready holds its value until the next edge
                while (!payload_ready) begin
                    saw_full = 1'b1;
                    @(posedge clk);
                    #1;
                end
                @(posedge clk);
                #1;
            end
        end
        payload_in.valid = 1'b0;
    endtask

    // cancel is sampled on the edge after it is driven
    task automatic abort_frame(input int f);
        while (cur_frame.size() != cancel_at[f] - 1) begin
            @(posedge clk);
            #1;
        end
        cancel = 1'b1;
        @(posedge clk);
        #1;
        cancel = 1'b0;
        check_phy($sformatf("%s cancel", test_name[f]), PHY_IDLE, phy);
    endtask

    initial begin
        rst = 1'b1;
        cancel = 1'b0;
        payload_in = '0;
        frames_seen = 0;
        idle_clocks = 0;
        gap_errs = 0;
        err_cnt = 0;
        check_cnt = 0;
        saw_full = 1'b0;
        void'($urandom(67986));
        make_payloads();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // nothing offered yet so the link stays idle
        repeat (IDLE_CHECK_CLOCKS) begin
            @(posedge clk);
            #1;
            check_phy("reset_state", PHY_IDLE, phy);
            check_count("reset_state payload_ready", 1, int'(payload_ready));
        end

        fork
            produce();
        join_none

        for (int f = 0; f < N_FRAMES; f++) begin
            if (cancel_at[f] != NO_CANCEL) begin
                abort_frame(f);
            end
            while (frames_seen < f + 1) begin
                @(posedge clk);
                #1;
            end
            score_frame(f);
        end

        check_count("inter-frame gap violations", 0, gap_errs);
        if (!saw_full) begin
            err_cnt++;
            $display("payload_ready never held off the producer");
        end
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d frames seen", WATCHDOG_NS,
                 frames_seen, N_FRAMES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== src.f ====
common/eth_tx_pkg.sv
eth_packer/crc32_dibit.sv
eth_packer/eth_packer.sv
verilog/payload_buffer.sv
verilog/eth_tx_top.sv
sim/eth_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the eth_tx testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module eth_tx_tb -f src.f

./obj_dir/Veth_tx_tb > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"
